//--- spi_master.f
verilog/spi_master_pkg.sv
verilog/spi_fifo.sv
verilog/spi_regs.sv
verilog/spi_clk_div.sv
verilog/spi_shift_fsm.sv
verilog/spi_master.sv
tests/tb_spi_master.sv

//--- run_sim.sh
#!/bin/sh
# Build the SPI master testbench with Verilator, run it, then check the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f spi_master.f \
    --top-module tb_spi_master \
    -Mdir "$BUILD_DIR" \
    -o sim_tb_spi_master

"./$BUILD_DIR/sim_tb_spi_master" | tee "$LOG"

if grep -q "^Simulation finished: PASS$" "$LOG"; then
    echo "Result: passed"
else
    echo "Result: failed"
    exit 1
fi

//--- tests/tb_spi_master.sv
`timescale 1ns/1ps

module tb_spi_master;
    import spi_master_pkg::*;

    localparam int MAX_CYCLES = 60000;              // Slow-rate test plus margin
    localparam int WAIT_LIMIT = 4000;               // Per wait, in cycles or polls

    logic                  clk_i;
    logic                  rstn_i;
    logic                  stb_i;
    logic                  we_i;
    addr_t                 addr_i;
    data_t                 data_i;
    spi_con_t              spi_con_i;
    data_t                 data_o;
    logic                  ack_o;
    logic                  int_o;
    logic                  sck_o;
    logic [NUM_SLAVES-1:0] ssn_o;
    logic                  mosi_o;
    logic                  miso_i;
    integer                seed;
    int                    errors;
    int                    tests_run;
    int                    cycles;

    assign miso_i = mosi_o;                         // Loopback, rx byte equals tx byte

    spi_master #(.FIFO_DEPTH(4)) spi_master_inst (
        .clk_i(clk_i), .rstn_i(rstn_i), .stb_i(stb_i), .we_i(we_i),
        .addr_i(addr_i), .data_i(data_i), .spi_con_i(spi_con_i),
        .data_o(data_o), .ack_o(ack_o), .int_o(int_o), .sck_o(sck_o),
        .ssn_o(ssn_o), .mosi_o(mosi_o), .miso_i(miso_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;                 // 40 ns period
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Protocol checks running all the time
    //////////////////////////////////////////////////

    assert property (@(posedge clk_i) disable iff (!rstn_i) ack_o |=> !ack_o)
        else begin
            $display("ack_o stayed high for more than one cycle at %0t ns", $time);
            errors++;
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
                     (&ssn_o) |-> (sck_o == spi_con_i.cpol))
        else begin
            $display("sck_o left its rest level with no slave selected at %0t ns", $time);
            errors++;
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(~ssn_o))
        else begin
            $display("More than one ssn_o line low at %0t ns", $time);
            errors++;
        end

    //////////////////////////////////////////////////
    // Bus and monitor tasks
    //////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk_i);
        #2;                                         // Drive point after the edge
    endtask

    task automatic check_value(input string name, input data_t got, input data_t exp);
        assert (got === exp) else begin
            $display("ERROR %0t ns %s: got 0x%02h, expected 0x%02h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic bus_access(input addr_t addr, input logic we, input data_t wdata,
                              output data_t rdata);
        int waited;
        waited = 0;
        stb_i  = 1'b1;
        we_i   = we;
        addr_i = addr;
        data_i = wdata;
        next_cycle();
        while (!ack_o && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        assert (ack_o) else begin
            $display("Bus access to address %0d got no acknowledge", addr);
            errors++;
        end
        rdata = data_o;                             // Valid while ack_o is high
        next_cycle();                               // Push, pop or clear lands here
        stb_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic write_reg(input addr_t addr, input data_t wdata);
        data_t unused;
        bus_access(addr, 1'b1, wdata, unused);
    endtask

    task automatic read_reg(input addr_t addr, output data_t rdata);
        bus_access(addr, 1'b0, 8'h00, rdata);
    endtask

    // Poll status until rx_empty drops
    task automatic wait_rx_byte();
        data_t sta;
        int    polls;
        polls = 0;
        read_reg(ADDR_STA, sta);
        while (sta[0] && polls < WAIT_LIMIT) begin
            read_reg(ADDR_STA, sta);
            polls++;
        end
        assert (!sta[0]) else begin
            $display("No received byte arrived while polling the status register");
            errors++;
        end
    endtask

    // Follows one byte from select low to select high, sampled on falling edges
    task automatic watch_byte(input logic [NUM_SLAVES-1:0] exp_ssn, input int half);
        int   waited;
        int   edges;
        int   since;
        logic sck_prev;
        waited = 0;
        edges  = 0;
        since  = 0;
        @(negedge clk_i);
        while ((&ssn_o) && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        sck_prev = sck_o;
        while (!(&ssn_o) && since < WAIT_LIMIT) begin
            @(negedge clk_i);
            since++;
            if (sck_o !== sck_prev) begin
                assert (ssn_o === exp_ssn) else begin
                    $display("ERROR %0t ns ssn_o: got %b, expected %b", $time, ssn_o, exp_ssn);
                    errors++;
                end
                if (half > 0 && edges > 0) begin   // First edge follows select, skip it
                    assert (since == half) else begin
                        $display("ERROR %0t ns sck_o half-period: got %0d, expected %0d",
                                 $time, since, half);
                        errors++;
                    end
                end
                edges++;
                since    = 0;
                sck_prev = sck_o;
            end
        end
        assert (edges == 16 && (&ssn_o)) else begin
            $display("Byte ended after %0d SCK edges with ssn_o %b", edges, ssn_o);
            errors++;
        end
        next_cycle();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        string verdict;
        tests_run++;
        if (errors == errs_before) begin
            verdict = "ok";
        end else begin
            verdict = "failed";
        end
        $display("Test %0d %s: %s, %0d errors", tests_run, name, verdict, errors - errs_before);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        data_t rd;
        data_t b;
        data_t sent [$];
        int    mark;
        seed      = 13708;
        errors    = 0;
        tests_run = 0;
        rstn_i    = 1'b0;
        stb_i     = 1'b0;
        we_i      = 1'b0;
        addr_i    = ADDR_CON;
        data_i    = 8'h00;
        spi_con_i = spi_con_t'(8'h5A);              // Core off, arbitrary fields for readback
        repeat (8) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;

        mark = errors;
        check_value("ssn_o", ssn_o, 8'hFF);
        check_value("ack_o", {7'b0, ack_o}, 8'h00);
        check_value("int_o", {7'b0, int_o}, 8'h00);
        read_reg(ADDR_STA, rd);
        check_value("status", rd, 8'h05);          // Both FIFOs empty
        read_reg(ADDR_EXT, rd);
        check_value("extension", rd, 8'h00);
        read_reg(ADDR_CON, rd);
        check_value("control", rd, spi_con_i);
        finish_test("reset values", mark);

        mark = errors;
        for (int mode = 0; mode < 4; mode++) begin
            spi_con_i        = '0;
            spi_con_i.spi_en = 1'b1;
            spi_con_i.cpol   = mode[1];
            spi_con_i.cpha   = mode[0];
            sent.delete();
            repeat (4) begin
                b = data_t'($random(seed));
                sent.push_back(b);
                write_reg(ADDR_DATA, b);
            end
            repeat (4) begin
                wait_rx_byte();
                read_reg(ADDR_DATA, rd);
                check_value("rx data", rd, sent.pop_front());
            end
        end
        finish_test("loopback in four modes", mark);

        mark = errors;
        spi_con_i        = '0;
        spi_con_i.spi_en = 1'b1;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            write_reg(ADDR_EXT, data_t'(s));
            b = data_t'($random(seed));
            write_reg(ADDR_DATA, b);
            watch_byte(~(8'h01 << s), 0);
            read_reg(ADDR_DATA, rd);
            check_value("rx data", rd, b);
        end
        finish_test("slave select", mark);

        mark = errors;
        write_reg(ADDR_EXT, 8'h00);
        for (int sel = 0; sel < 3; sel++) begin
            spi_con_i.sck_sel = 3'(sel);
            b = data_t'($random(seed));
            write_reg(ADDR_DATA, b);
            watch_byte(8'hFE, 2 << sel);            // Divisor 4, 8, 16 halved
            read_reg(ADDR_DATA, rd);
            check_value("rx data", rd, b);
        end
        finish_test("SCK rate", mark);

        mark = errors;
        spi_con_i.sck_sel = 3'd0;
        write_reg(ADDR_EXT, 8'h80);                 // intcnt_sel 2
        write_reg(ADDR_STA, 8'h80);                 // Drop flag from earlier bytes
        spi_con_i.int_en = 1'b1;
        for (int i = 1; i <= 3; i++) begin
            b = data_t'($random(seed));
            write_reg(ADDR_DATA, b);
            wait_rx_byte();
            read_reg(ADDR_DATA, rd);
            check_value("rx data", rd, b);
            read_reg(ADDR_STA, rd);
            check_value("status int_f", {7'b0, rd[7]}, (i == 3) ? 8'h01 : 8'h00);
            check_value("int_o", {7'b0, int_o}, (i == 3) ? 8'h01 : 8'h00);
        end
        write_reg(ADDR_STA, 8'h80);
        check_value("int_o", {7'b0, int_o}, 8'h01);  // Registered, one cycle behind
        next_cycle();
        check_value("int_o", {7'b0, int_o}, 8'h00);
        read_reg(ADDR_STA, rd);
        check_value("status int_f", {7'b0, rd[7]}, 8'h00);
        finish_test("interrupt", mark);

        mark = errors;
        spi_con_i.int_en  = 1'b0;
        spi_con_i.sck_sel = 3'd7;                   // Slowest rate keeps the tx FIFO full
        repeat (6) begin
            write_reg(ADDR_DATA, data_t'($random(seed)));
        end
        read_reg(ADDR_STA, rd);
        check_value("status wcol_f", {7'b0, rd[6]}, 8'h01);
        check_value("status tx_full", {7'b0, rd[3]}, 8'h01);
        write_reg(ADDR_STA, 8'h40);
        read_reg(ADDR_STA, rd);
        check_value("status wcol_f", {7'b0, rd[6]}, 8'h00);
        spi_con_i.spi_en = 1'b0;
        next_cycle();
        read_reg(ADDR_STA, rd);
        check_value("status", rd, 8'h05);          // FIFOs flushed
        finish_test("write collision", mark);

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/spi_master.sv
`timescale 1ns/1ps

module spi_master #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,
    input  logic                                  stb_i,
    input  logic                                  we_i,
    input  spi_master_pkg::addr_t                 addr_i,
    input  spi_master_pkg::data_t                 data_i,
    input  spi_master_pkg::spi_con_t              spi_con_i,
    output spi_master_pkg::data_t                 data_o,
    output logic                                  ack_o,
    output logic                                  int_o,
    output logic                                  sck_o,
    output logic [spi_master_pkg::NUM_SLAVES-1:0] ssn_o,
    output logic                                  mosi_o,
    input  logic                                  miso_i
);
    import spi_master_pkg::*;

    data_t       tx_data;                           // Tx FIFO head to shifter
    data_t       rx_data;                           // Rx FIFO head to read mux
    data_t       rx_byte;                           // Shifter to rx FIFO
    fifo_flags_t tx_flags;
    fifo_flags_t rx_flags;
    spi_ext_t    spi_ext;
    logic        tx_push;
    logic        tx_pop;
    logic        rx_push;
    logic        rx_pop;
    logic        tick;
    logic        busy;
    logic        fifo_clr;

    assign fifo_clr = ~spi_con_i.spi_en;            // Disabled core flushes both FIFOs

    spi_regs regs_inst (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .stb_i(stb_i), .we_i(we_i), .addr_i(addr_i), .data_i(data_i),
        .con_i(spi_con_i), .tx_flags_i(tx_flags), .rx_flags_i(rx_flags),
        .rx_data_i(rx_data), .rx_push_i(rx_push),
        .data_o(data_o), .ack_o(ack_o), .int_o(int_o), .ext_o(spi_ext),
        .tx_push_o(tx_push), .rx_pop_o(rx_pop)
    );

    spi_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
        .clk_i(clk_i), .rstn_i(rstn_i), .clr_i(fifo_clr),
        .din_i(data_i), .push_i(tx_push), .pop_i(tx_pop),
        .dout_o(tx_data), .flags_o(tx_flags)
    );

    spi_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
        .clk_i(clk_i), .rstn_i(rstn_i), .clr_i(fifo_clr),
        .din_i(rx_byte), .push_i(rx_push), .pop_i(rx_pop),
        .dout_o(rx_data), .flags_o(rx_flags)
    );

    spi_clk_div clk_div_inst (
        .clk_i(clk_i), .rstn_i(rstn_i), .con_i(spi_con_i),
        .busy_i(busy), .tick_o(tick)
    );

    spi_shift_fsm shift_inst (
        .clk_i(clk_i), .rstn_i(rstn_i), .con_i(spi_con_i), .ext_i(spi_ext),
        .tick_i(tick), .tx_data_i(tx_data), .tx_flags_i(tx_flags), .miso_i(miso_i),
        .busy_o(busy), .tx_pop_o(tx_pop), .rx_push_o(rx_push), .rx_data_o(rx_byte),
        .sck_o(sck_o), .mosi_o(mosi_o), .ssn_o(ssn_o)
    );

endmodule

//--- verilog/spi_shift_fsm.sv
`timescale 1ns/1ps

module spi_shift_fsm (
    input  logic                                 clk_i,
    input  logic                                 rstn_i,
    input  spi_master_pkg::spi_con_t             con_i,
    input  spi_master_pkg::spi_ext_t             ext_i,
    input  logic                                 tick_i,
    input  spi_master_pkg::data_t                tx_data_i,  // Tx FIFO head
    input  spi_master_pkg::fifo_flags_t          tx_flags_i,
    input  logic                                 miso_i,
    output logic                                 busy_o,
    output logic                                 tx_pop_o,
    output logic                                 rx_push_o,
    output spi_master_pkg::data_t                rx_data_o,
    output logic                                 sck_o,
    output logic                                 mosi_o,
    output logic [spi_master_pkg::NUM_SLAVES-1:0] ssn_o
);
    import spi_master_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'b000,
        ST_START  = 3'b001,                         // Waiting for first leading edge
        ST_PHASE2 = 3'b011,                         // Waiting for a leading edge
        ST_PHASE1 = 3'b010,                         // Waiting for a trailing edge
        ST_CONT   = 3'b110                          // Byte done, next or stop
    } state_t;

    state_t     state;
    data_t      data_buf;                           // Tx out of bit 7, rx in at bit 0
    data_t      shift_in;
    logic [2:0] bit_cnt;
    logic       sck_q;                              // SCK phase, zero at rest
    logic       sel_act;                            // Slave selected

    assign busy_o    = (state != ST_IDLE);
    assign shift_in  = {data_buf[6:0], miso_i};
    assign rx_data_o = data_buf;
    assign mosi_o    = data_buf[7];
    assign sck_o     = sck_q ^ con_i.cpol;          // Rest level follows cpol
    assign ssn_o     = ~(NUM_SLAVES'(sel_act) << ext_i.slave_sel);

    //////////////////////////////////////////////////
    // Sixteen ticks per byte, one SCK edge each
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state     <= ST_IDLE;
            data_buf  <= '0;
            bit_cnt   <= 3'd0;
            sck_q     <= 1'b0;
            sel_act   <= 1'b0;
            tx_pop_o  <= 1'b0;
            rx_push_o <= 1'b0;
        end else begin
            tx_pop_o  <= 1'b0;
            rx_push_o <= 1'b0;
            if (!con_i.spi_en) begin                // Abort any byte in flight
                state   <= ST_IDLE;
                sck_q   <= 1'b0;
                sel_act <= 1'b0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (!tx_flags_i.empty) begin
                            data_buf <= tx_data_i;  // MSB out before first edge
                            bit_cnt  <= 3'd7;
                            tx_pop_o <= 1'b1;
                            sel_act  <= 1'b1;
                            state    <= ST_START;
                        end
                    end
                    ST_START: begin
                        if (tick_i) begin
                            sck_q <= ~sck_q;
                            state <= ST_PHASE1;
                        end
                    end
                    ST_PHASE2: begin
                        if (tick_i) begin
                            sck_q <= ~sck_q;
                            if (con_i.cpha) begin
                                data_buf <= shift_in;   // Mode 1 launches on leading edge
                            end
                            state <= ST_PHASE1;
                        end
                    end
                    ST_PHASE1: begin
                        if (tick_i) begin
                            sck_q <= ~sck_q;
                            if (!con_i.cpha || (bit_cnt == 3'd0)) begin
                                data_buf <= shift_in;   // Last bit always taken here
                            end
                            if (bit_cnt == 3'd0) begin
                                rx_push_o <= 1'b1;
                                state     <= ST_CONT;
                            end else begin
                                bit_cnt <= bit_cnt - 3'd1;
                                state   <= ST_PHASE2;
                            end
                        end
                    end
                    ST_CONT: begin
                        if (tx_flags_i.empty) begin
                            sel_act <= 1'b0;
                            state   <= ST_IDLE;
                        end else begin
                            data_buf <= tx_data_i;  // Rx FIFO takes old byte this edge
                            bit_cnt  <= 3'd7;
                            tx_pop_o <= 1'b1;
                            state    <= ST_START;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

//--- verilog/spi_clk_div.sv
`timescale 1ns/1ps

module spi_clk_div (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  spi_master_pkg::spi_con_t con_i,
    input  logic                     busy_i,        // Transfer in progress
    output logic                     tick_o         // One SCK half-period elapsed
);
    import spi_master_pkg::*;

    logic [CLK_CNT_W-1:0] clk_cnt;
    logic                 run;

    assign run    = busy_i & con_i.spi_en;
    assign tick_o = run & (clk_cnt == '0);

    // Period of tick_o is reload+1 cycles
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            clk_cnt <= '0;
        end else if (run && (clk_cnt != '0)) begin
            clk_cnt <= clk_cnt - 1'b1;
        end else begin
            clk_cnt <= SCK_RELOAD[con_i.sck_sel];   // Idle or terminal count
        end
    end

endmodule

//--- verilog/spi_regs.sv
`timescale 1ns/1ps

module spi_regs (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        stb_i,
    input  logic                        we_i,
    input  spi_master_pkg::addr_t       addr_i,
    input  spi_master_pkg::data_t       data_i,
    input  spi_master_pkg::spi_con_t    con_i,
    input  spi_master_pkg::fifo_flags_t tx_flags_i,
    input  spi_master_pkg::fifo_flags_t rx_flags_i,
    input  spi_master_pkg::data_t       rx_data_i,  // Rx FIFO head
    input  logic                        rx_push_i,  // One per received byte
    output spi_master_pkg::data_t       data_o,
    output logic                        ack_o,
    output logic                        int_o,
    output spi_master_pkg::spi_ext_t    ext_o,
    output logic                        tx_push_o,
    output logic                        rx_pop_o
);
    import spi_master_pkg::*;

    spi_ext_t   ext_q;
    spi_ext_t   ext_wr;                             // Bus data seen as extension word
    spi_sta_t   sta;
    logic       int_f;
    logic       wcol_f;
    logic [1:0] trans_cnt;                          // Bytes left before next interrupt
    logic       bus_acc;
    logic       wr_sta;
    logic       wr_ext;
    logic       wr_data;
    logic       int_rq;

    //////////////////////////////////////////////////
    // Access decode, all side effects in the ack cycle
    //////////////////////////////////////////////////

    assign bus_acc   = stb_i & ack_o;
    assign wr_sta    = bus_acc & we_i & (addr_i == ADDR_STA);
    assign wr_ext    = bus_acc & we_i & (addr_i == ADDR_EXT);
    assign wr_data   = bus_acc & we_i & (addr_i == ADDR_DATA);
    assign rx_pop_o  = bus_acc & ~we_i & (addr_i == ADDR_DATA);
    assign tx_push_o = wr_data & ~tx_flags_i.full;  // Full FIFO drops the byte
    assign ext_wr    = spi_ext_t'(data_i);
    assign ext_o     = ext_q;
    assign int_rq    = rx_push_i & (trans_cnt == 2'd0);

    always_comb begin
        sta          = '0;                          // Bits 5:4 read zero
        sta.int_f    = int_f;
        sta.wcol_f   = wcol_f;
        sta.tx_full  = tx_flags_i.full;
        sta.tx_empty = tx_flags_i.empty;
        sta.rx_full  = rx_flags_i.full;
        sta.rx_empty = rx_flags_i.empty;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_o  <= 1'b0;
            data_o <= '0;
        end else begin
            ack_o <= stb_i & ~ack_o;                // Single cycle per strobe
            case (addr_i)
                ADDR_CON: data_o <= con_i;
                ADDR_STA: data_o <= sta;
                ADDR_DATA: data_o <= rx_data_i;
                default: data_o <= ext_q;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Extension register and transfer counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ext_q     <= '0;
            trans_cnt <= 2'd0;
        end else begin
            if (wr_ext) begin
                ext_q     <= ext_wr;
                trans_cnt <= ext_wr.intcnt_sel;     // Restart count with new setting
            end else if (rx_push_i) begin
                trans_cnt <= (trans_cnt == 2'd0) ? ext_q.intcnt_sel : trans_cnt - 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Status flags, W1C wins over a new set
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            int_f  <= 1'b0;
            wcol_f <= 1'b0;
            int_o  <= 1'b0;
        end else begin
            if (wr_sta && data_i[7]) begin
                int_f <= 1'b0;
            end else if (int_rq) begin
                int_f <= 1'b1;
            end
            if (wr_sta && data_i[6]) begin
                wcol_f <= 1'b0;
            end else if (wr_data && tx_flags_i.full) begin
                wcol_f <= 1'b1;                     // Write hit a full tx FIFO
            end
            int_o <= con_i.int_en & int_f;
        end
    end

endmodule

//--- verilog/spi_fifo.sv
`timescale 1ns/1ps

module spi_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        clr_i,      // Synchronous flush
    input  spi_master_pkg::data_t       din_i,
    input  logic                        push_i,
    input  logic                        pop_i,
    output spi_master_pkg::data_t       dout_o,     // Oldest entry
    output spi_master_pkg::fifo_flags_t flags_o
);
    import spi_master_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

    data_t            mem [FIFO_DEPTH];             // Storage, no reset
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                        // Occupancy
    logic             do_push;
    logic             do_pop;

    assign flags_o.full  = (count == CNT_FULL);
    assign flags_o.empty = (count == '0);
    assign do_push       = push_i & ~flags_o.full;  // Push to a full FIFO is lost
    assign do_pop        = pop_i & ~flags_o.empty;  // Pop of an empty FIFO is ignored
    assign dout_o        = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;   // Wrap at depth
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push != do_pop) begin
                count <= do_push ? count + 1'b1 : count - 1'b1;       // Both at once holds
            end
        end
    end

endmodule

//--- verilog/spi_master_pkg.sv
package spi_master_pkg;

    typedef logic [7:0] data_t;                     // One bus or SPI byte
    typedef logic [1:0] addr_t;                     // Register select

    localparam addr_t ADDR_CON  = 2'd0;             // Control word, mirror of spi_con_i
    localparam addr_t ADDR_STA  = 2'd1;             // Status, W1C on bits 7:6
    localparam addr_t ADDR_DATA = 2'd2;             // Tx push on write, rx pop on read
    localparam addr_t ADDR_EXT  = 2'd3;             // Extension register

    typedef struct packed {
        logic       spi_en;                         // Core enable, FIFOs clear when low
        logic       int_en;                         // Interrupt output enable
        logic       reserved;
        logic       cpol;                           // SCK rest level
        logic       cpha;                           // Launch on leading edge when set
        logic [2:0] sck_sel;                        // Index into SCK_RELOAD
    } spi_con_t;

    typedef struct packed {
        logic [1:0] intcnt_sel;                     // Interrupt every intcnt_sel+1 bytes
        logic [2:0] reserved;                       // Kept as written
        logic [2:0] slave_sel;                      // Active ssn_o line
    } spi_ext_t;

    typedef struct packed {
        logic       int_f;
        logic       wcol_f;
        logic [1:0] zero;
        logic       tx_full;
        logic       tx_empty;
        logic       rx_full;
        logic       rx_empty;
    } spi_sta_t;

    typedef struct packed {
        logic full;
        logic empty;
    } fifo_flags_t;

    localparam int CLK_CNT_W  = 13;                 // Fits the largest reload
    localparam int NUM_SLAVES = 8;

    // Half-period reload per sck_sel, SCK divisor is 2*(reload+1)
    localparam logic [7:0][CLK_CNT_W-1:0] SCK_RELOAD = {
        13'd8191, 13'd2047, 13'd511, 13'd127,
        13'd31,   13'd7,    13'd3,   13'd1
    };

endpackage
